// File: hw/rv_ctrl_decoder.sv
// rv64im control decoder, turns one instruction into alu, branch, memory and imm controls
`default_nettype none

module rv_ctrl_decoder (
  input  rv_decode_pkg::inst_t i_inst,
  rv_ctrl_if.dec               ctrl
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [7:0] f3;
  logic       f7_base, f7_alt, f7_mext, sh_base, sh_alt;
  logic       op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load;
  logic       op_store, op_imm, op_imm32, op_reg, op_reg32, op_system;
  logic [7:0] imm_f3, imm32_f3, br_f3, ld_f3, st_f3;
  logic [7:0] rb_f3, ra_f3, rm_f3, wb_f3, wa_f3, wm_f3;
  logic       jalr_ok, br_ok, ld_ok, st_ok, is_ebreak, alu_hit;
  logic       type_r, type_i, type_u, type_s, type_j;
  logic       sel_copy, sel_add, sel_sub, sel_slt, sel_sltu, sel_xor, sel_and, sel_or;
  logic       sel_sll, sel_srl, sel_sra, sel_mul, sel_mulh, sel_mulhsu, sel_mulhu;
  logic       sel_div, sel_divu, sel_rem, sel_remu;
  alu_op_t    alu_op;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign f3     = 8'd1 << funct3;  // one bit per funct3 value

  assign f7_base = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  assign f7_mext = (funct7 == 7'b0000001);
  assign sh_base = (funct7[6:1] == 6'b000000);  // rv64 shamt is 6 bits
  assign sh_alt  = (funct7[6:1] == 6'b010000);

  assign op_lui    = (opcode == OP_LUI);
  assign op_auipc  = (opcode == OP_AUIPC);
  assign op_jal    = (opcode == OP_JAL);
  assign op_jalr   = (opcode == OP_JALR);
  assign op_branch = (opcode == OP_BRANCH);
  assign op_load   = (opcode == OP_LOAD);
  assign op_store  = (opcode == OP_STORE);
  assign op_imm    = (opcode == OP_IMM);
  assign op_imm32  = (opcode == OP_IMM_32);
  assign op_reg    = (opcode == OP_REG);
  assign op_reg32  = (opcode == OP_REG_32);
  assign op_system = (opcode == OP_SYSTEM);

  assign imm_f3   = op_imm ? f3 : '0;
  assign imm32_f3 = op_imm32 ? f3 : '0;
  assign br_f3    = op_branch ? f3 : '0;
  assign ld_f3    = op_load ? f3 : '0;
  assign st_f3    = op_store ? f3 : '0;
  assign rb_f3    = (op_reg && f7_base) ? f3 : '0;
  assign ra_f3    = (op_reg && f7_alt) ? f3 : '0;     // sub, sra
  assign rm_f3    = (op_reg && f7_mext) ? f3 : '0;
  assign wb_f3    = (op_reg32 && f7_base) ? f3 : '0;
  assign wa_f3    = (op_reg32 && f7_alt) ? f3 : '0;
  assign wm_f3    = (op_reg32 && f7_mext) ? f3 : '0;

  assign jalr_ok   = op_jalr & f3[0];
  assign br_ok     = |{br_f3[7:4], br_f3[1:0]};
  assign ld_ok     = |ld_f3[6:0];                     // no funct3 7 load
  assign st_ok     = |st_f3[3:0];
  assign is_ebreak = op_system & f3[0] & (i_inst[31:20] == 12'd1);

  assign sel_copy   = op_lui;
  assign sel_add    = |{op_auipc, op_jal, jalr_ok, ld_ok, st_ok,
                        imm_f3[0], imm32_f3[0], rb_f3[0], wb_f3[0]};
  assign sel_sub    = ra_f3[0] | wa_f3[0];
  assign sel_slt    = |{br_f3[0], br_f3[1], br_f3[4], br_f3[5], imm_f3[2], rb_f3[2]};
  assign sel_sltu   = |{br_f3[6], br_f3[7], imm_f3[3], rb_f3[3]};
  assign sel_xor    = imm_f3[4] | rb_f3[4];
  assign sel_or     = imm_f3[6] | rb_f3[6];
  assign sel_and    = imm_f3[7] | rb_f3[7];
  assign sel_sll    = |{imm_f3[1] & sh_base, imm32_f3[1] & f7_base, rb_f3[1], wb_f3[1]};
  assign sel_srl    = |{imm_f3[5] & sh_base, imm32_f3[5] & f7_base, rb_f3[5], wb_f3[5]};
  assign sel_sra    = |{imm_f3[5] & sh_alt, imm32_f3[5] & f7_alt, ra_f3[5], wa_f3[5]};
  assign sel_mul    = rm_f3[0] | wm_f3[0];
  assign sel_mulh   = rm_f3[1];
  assign sel_mulhsu = rm_f3[2];
  assign sel_mulhu  = rm_f3[3];
  assign sel_div    = rm_f3[4] | wm_f3[4];
  assign sel_divu   = rm_f3[5] | wm_f3[5];
  assign sel_rem    = rm_f3[6] | wm_f3[6];
  assign sel_remu   = rm_f3[7] | wm_f3[7];

  always_comb begin
    case (1'b1)
      sel_copy:   alu_op = ALU_COPY_IMM;
      sel_add:    alu_op = ALU_ADD;
      sel_sub:    alu_op = ALU_SUB;
      sel_slt:    alu_op = ALU_SLT;
      sel_sltu:   alu_op = ALU_SLTU;
      sel_xor:    alu_op = ALU_XOR;
      sel_and:    alu_op = ALU_AND;
      sel_or:     alu_op = ALU_OR;
      sel_sll:    alu_op = ALU_SLL;
      sel_srl:    alu_op = ALU_SRL;
      sel_sra:    alu_op = ALU_SRA;
      sel_mul:    alu_op = ALU_MUL;
      sel_mulh:   alu_op = ALU_MULH;
      sel_mulhsu: alu_op = ALU_MULHSU;
      sel_mulhu:  alu_op = ALU_MULHU;
      sel_div:    alu_op = ALU_DIV;
      sel_divu:   alu_op = ALU_DIVU;
      sel_rem:    alu_op = ALU_REM;
      sel_remu:   alu_op = ALU_REMU;
      default:    alu_op = ALU_INVALID;
    endcase
  end

  assign alu_hit = (alu_op != ALU_INVALID);
  assign type_r  = (op_reg | op_reg32) & alu_hit;
  assign type_i  = jalr_ok | ld_ok | ((op_imm | op_imm32) & alu_hit) | is_ebreak;
  assign type_u  = op_lui | op_auipc;
  assign type_s  = st_ok;
  assign type_j  = op_jal;

  always_comb begin
    case (1'b1)
      ld_f3[0] | st_f3[0]: ctrl.mem_op = MEM_B;
      ld_f3[4]:            ctrl.mem_op = MEM_BU;
      ld_f3[1] | st_f3[1]: ctrl.mem_op = MEM_H;
      ld_f3[5]:            ctrl.mem_op = MEM_HU;
      ld_f3[2] | st_f3[2]: ctrl.mem_op = MEM_W;
      ld_f3[6]:            ctrl.mem_op = MEM_WU;
      ld_f3[3] | st_f3[3]: ctrl.mem_op = MEM_D;
      default:             ctrl.mem_op = MEM_NONE;
    endcase
  end

  always_comb begin
    case (1'b1)
      op_jal:              ctrl.br_func = BR_JAL;
      jalr_ok:             ctrl.br_func = BR_JALR;
      br_f3[0]:            ctrl.br_func = BR_EQ;
      br_f3[1]:            ctrl.br_func = BR_NE;
      br_f3[4] | br_f3[6]: ctrl.br_func = BR_LT;
      br_f3[5] | br_f3[7]: ctrl.br_func = BR_GE;
      default:             ctrl.br_func = BR_NONE;
    endcase
  end

  always_comb begin
    case (1'b1)
      type_i:  ctrl.imm_fmt = IMM_I;
      type_u:  ctrl.imm_fmt = IMM_U;
      type_s:  ctrl.imm_fmt = IMM_S;
      br_ok:   ctrl.imm_fmt = IMM_B;
      type_j:  ctrl.imm_fmt = IMM_J;
      default: ctrl.imm_fmt = IMM_NONE;
    endcase
  end

  assign ctrl.alu_op    = alu_op;
  assign ctrl.alu_a_pc  = op_jal | jalr_ok | op_auipc;
  assign ctrl.alu_b_src = (op_jal | jalr_ok) ? SRC_B_FOUR :
                          (type_i | type_u | type_s) ? SRC_B_IMM : SRC_B_RS2;
  assign ctrl.mem_rd    = ld_ok;
  assign ctrl.mem_wr    = st_ok;
  assign ctrl.reg_wr    = type_r | type_i | type_u | type_j;  // ebreak included
  assign ctrl.word_cut  = (op_imm32 | op_reg32) & alu_hit;
  assign ctrl.ebreak    = is_ebreak;
  assign ctrl.illegal   = ~alu_hit & ~is_ebreak & (i_inst != '0);

  // width table and access enables must agree
  always_comb begin
    a_mem_excl: assert final (!(ctrl.mem_rd && ctrl.mem_wr) &&
                              ((ctrl.mem_rd || ctrl.mem_wr) == (ctrl.mem_op != MEM_NONE)))
      else $error("memory access decode inconsistent, inst %h", i_inst);
  end

endmodule

`default_nettype wire

// File: hw/rv_ctrl_if.sv
// control bundle from the instruction decoder to the decode stage register
`default_nettype none

interface rv_ctrl_if;
  import rv_decode_pkg::*;

  alu_op_t    alu_op;
  logic       alu_a_pc;    // pc as operand a
  alu_b_src_t alu_b_src;
  br_func_t   br_func;
  logic       mem_rd;
  logic       mem_wr;
  mem_op_t    mem_op;
  logic       reg_wr;
  logic       word_cut;    // *w forms
  imm_fmt_t   imm_fmt;
  logic       ebreak;
  logic       illegal;

  modport dec (
    output alu_op, alu_a_pc, alu_b_src, br_func,
    output mem_rd, mem_wr, mem_op, reg_wr, word_cut,
    output imm_fmt, ebreak, illegal
  );

  modport stage (
    input alu_op, alu_a_pc, alu_b_src, br_func,
    input mem_rd, mem_wr, mem_op, reg_wr, word_cut,
    input imm_fmt, ebreak, illegal
  );

endinterface

`default_nettype wire

// File: hw/rv_decode_pkg.sv
// rv64im decode package with widths, data types, opcodes and control field codes
`default_nettype none

package rv_decode_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]              xlen_t;
  typedef logic [31:0]                  inst_t;
  typedef logic [$clog2(NUM_REGS)-1:0]  reg_addr_t;
  typedef logic [4:0]                   alu_op_t;
  typedef logic [2:0]                   mem_op_t;
  typedef logic [2:0]                   br_func_t;
  typedef logic [1:0]                   alu_b_src_t;
  typedef logic [2:0]                   imm_fmt_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG_32 = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam alu_op_t ALU_ADD      = 5'd0;
  localparam alu_op_t ALU_SUB      = 5'd1;
  localparam alu_op_t ALU_SLT      = 5'd2;   // also signed branch compare
  localparam alu_op_t ALU_SLTU     = 5'd3;
  localparam alu_op_t ALU_XOR      = 5'd4;
  localparam alu_op_t ALU_AND      = 5'd5;
  localparam alu_op_t ALU_OR       = 5'd6;
  localparam alu_op_t ALU_SLL      = 5'd7;
  localparam alu_op_t ALU_SRL      = 5'd8;
  localparam alu_op_t ALU_SRA      = 5'd9;
  localparam alu_op_t ALU_MUL      = 5'd10;
  localparam alu_op_t ALU_DIV      = 5'd11;
  localparam alu_op_t ALU_DIVU     = 5'd12;
  localparam alu_op_t ALU_REM      = 5'd13;
  localparam alu_op_t ALU_REMU     = 5'd14;
  localparam alu_op_t ALU_COPY_IMM = 5'd15;  // lui
  localparam alu_op_t ALU_MULH     = 5'd25;
  localparam alu_op_t ALU_MULHSU   = 5'd26;
  localparam alu_op_t ALU_MULHU    = 5'd27;
  localparam alu_op_t ALU_INVALID  = 5'd31;

  // stores use the signed code of their width
  localparam mem_op_t MEM_B    = 3'd0;
  localparam mem_op_t MEM_BU   = 3'd1;
  localparam mem_op_t MEM_H    = 3'd2;
  localparam mem_op_t MEM_HU   = 3'd3;
  localparam mem_op_t MEM_W    = 3'd4;
  localparam mem_op_t MEM_WU   = 3'd5;
  localparam mem_op_t MEM_D    = 3'd6;
  localparam mem_op_t MEM_NONE = 3'd7;

  localparam br_func_t BR_NONE = 3'd0;
  localparam br_func_t BR_JAL  = 3'd1;
  localparam br_func_t BR_JALR = 3'd2;
  localparam br_func_t BR_EQ   = 3'd4;
  localparam br_func_t BR_NE   = 3'd5;
  localparam br_func_t BR_LT   = 3'd6;   // signedness comes from the alu code
  localparam br_func_t BR_GE   = 3'd7;

  localparam alu_b_src_t SRC_B_RS2  = 2'd0;
  localparam alu_b_src_t SRC_B_IMM  = 2'd1;
  localparam alu_b_src_t SRC_B_FOUR = 2'd2;  // link address pc + 4

  localparam imm_fmt_t IMM_I    = 3'd0;
  localparam imm_fmt_t IMM_U    = 3'd1;
  localparam imm_fmt_t IMM_S    = 3'd2;
  localparam imm_fmt_t IMM_B    = 3'd3;
  localparam imm_fmt_t IMM_J    = 3'd4;
  localparam imm_fmt_t IMM_NONE = 3'd7;

endpackage

`default_nettype wire

// File: hw/rv_decode_stage.sv
// decode stage register, builds the immediate and latches control, operands and rd
`default_nettype none

module rv_decode_stage (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_inst_valid,
  input  rv_decode_pkg::inst_t      i_inst,
  rv_ctrl_if.stage                  ctrl,
  input  rv_decode_pkg::xlen_t      i_rs1_data,
  input  rv_decode_pkg::xlen_t      i_rs2_data,
  output logic                      o_valid,
  output rv_decode_pkg::reg_addr_t  o_rd,
  output rv_decode_pkg::xlen_t      o_rs1_data,
  output rv_decode_pkg::xlen_t      o_rs2_data,
  output rv_decode_pkg::xlen_t      o_imm,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output logic                      o_alu_a_pc,
  output rv_decode_pkg::alu_b_src_t o_alu_b_src,
  output rv_decode_pkg::br_func_t   o_br_func,
  output logic                      o_reg_wr,
  output logic                      o_mem_rd,
  output logic                      o_mem_wr,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_word_cut,
  output logic                      o_ebreak,
  output logic                      o_illegal
);
  import rv_decode_pkg::*;

  xlen_t imm;

  always_comb begin
    case (ctrl.imm_fmt)
      IMM_I:   imm = {{52{i_inst[31]}}, i_inst[31:20]};
      IMM_U:   imm = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
      IMM_S:   imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      IMM_B:   imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      IMM_J:   imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      default: imm = '0;  // r-type and unknown
    endcase
  end

  // side-effect controls drop on a bubble
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid  <= 1'b0;
      o_reg_wr <= 1'b0;
      o_mem_rd <= 1'b0;
      o_mem_wr <= 1'b0;
      o_mem_op <= MEM_NONE;
    end else begin
      o_valid  <= i_inst_valid;
      o_reg_wr <= i_inst_valid & ctrl.reg_wr;
      o_mem_rd <= i_inst_valid & ctrl.mem_rd;
      o_mem_wr <= i_inst_valid & ctrl.mem_wr;
      if (i_inst_valid) begin
        o_mem_op <= ctrl.mem_op;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin  // hold on a bubble
      o_rd        <= i_inst[11:7];
      o_rs1_data  <= i_rs1_data;
      o_rs2_data  <= i_rs2_data;
      o_imm       <= imm;
      o_alu_op    <= ctrl.alu_op;
      o_alu_a_pc  <= ctrl.alu_a_pc;
      o_alu_b_src <= ctrl.alu_b_src;
      o_br_func   <= ctrl.br_func;
      o_word_cut  <= ctrl.word_cut;
      o_ebreak    <= ctrl.ebreak;
      o_illegal   <= ctrl.illegal;
    end
  end

  a_valid_known: assert property (@(posedge i_clk) disable iff (i_reset)
    !$isunknown(o_valid))
    else $error("o_valid unknown after reset");

endmodule

`default_nettype wire

// File: hw/rv_decode_unit.sv
// rv64im decode unit top, decoder and register file feeding the decode stage register
`default_nettype none

module rv_decode_unit (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_inst_valid,
  input  rv_decode_pkg::inst_t      i_inst,
  input  logic                      i_wb_en,
  input  rv_decode_pkg::reg_addr_t  i_wb_addr,
  input  rv_decode_pkg::xlen_t      i_wb_data,
  output logic                      o_valid,
  output rv_decode_pkg::reg_addr_t  o_rd,
  output rv_decode_pkg::xlen_t      o_rs1_data,
  output rv_decode_pkg::xlen_t      o_rs2_data,
  output rv_decode_pkg::xlen_t      o_imm,
  output rv_decode_pkg::alu_op_t    o_alu_op,
  output logic                      o_alu_a_pc,
  output rv_decode_pkg::alu_b_src_t o_alu_b_src,
  output rv_decode_pkg::br_func_t   o_br_func,
  output logic                      o_reg_wr,
  output logic                      o_mem_rd,
  output logic                      o_mem_wr,
  output rv_decode_pkg::mem_op_t    o_mem_op,
  output logic                      o_word_cut,
  output logic                      o_ebreak,
  output logic                      o_illegal
);
  import rv_decode_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  assign rs1_addr = i_inst[19:15];
  assign rs2_addr = i_inst[24:20];

  rv_ctrl_if ctrl_bus ();

  rv_ctrl_decoder u_decoder (
    .i_inst (i_inst),
    .ctrl   (ctrl_bus)
  );

  rv_gpr_file u_gpr (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1      (rs1_addr),
    .i_rs2      (rs2_addr),
    .i_wb_en    (i_wb_en),
    .i_wb_addr  (i_wb_addr),
    .i_wb_data  (i_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_decode_stage u_stage (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .ctrl         (ctrl_bus),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_valid      (o_valid),
    .o_rd         (o_rd),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data),
    .o_imm        (o_imm),
    .o_alu_op     (o_alu_op),
    .o_alu_a_pc   (o_alu_a_pc),
    .o_alu_b_src  (o_alu_b_src),
    .o_br_func    (o_br_func),
    .o_reg_wr     (o_reg_wr),
    .o_mem_rd     (o_mem_rd),
    .o_mem_wr     (o_mem_wr),
    .o_mem_op     (o_mem_op),
    .o_word_cut   (o_word_cut),
    .o_ebreak     (o_ebreak),
    .o_illegal    (o_illegal)
  );

endmodule

`default_nettype wire

// File: hw/rv_gpr_file.sv
// general register file, 32 x 64 bit, two async reads with write bypass, x0 reads zero
`default_nettype none

module rv_gpr_file (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  rv_decode_pkg::reg_addr_t i_rs1,
  input  rv_decode_pkg::reg_addr_t i_rs2,
  input  logic                     i_wb_en,
  input  rv_decode_pkg::reg_addr_t i_wb_addr,
  input  rv_decode_pkg::xlen_t     i_wb_data,
  output rv_decode_pkg::xlen_t     o_rs1_data,
  output rv_decode_pkg::xlen_t     o_rs2_data
);
  import rv_decode_pkg::*;

  xlen_t regs [NUM_REGS];

  // x0 first, then same-cycle write-back, then the array
  function automatic xlen_t read_port(input reg_addr_t addr);
    xlen_t data;
    if (addr == '0) begin
      data = '0;
    end else if (i_wb_en && (i_wb_addr == addr)) begin
      data = i_wb_data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_wb_en && (i_wb_addr != '0)) begin  // x0 is never written
      regs[i_wb_addr] <= i_wb_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

  a_x0_rs1: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_rs1 == '0) |-> (o_rs1_data == '0))
    else $error("x0 read on rs1 gave %h", o_rs1_data);

  a_x0_rs2: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_rs2 == '0) |-> (o_rs2_data == '0))
    else $error("x0 read on rs2 gave %h", o_rs2_data);

endmodule

`default_nettype wire

// File: rv_decode_unit.f
hw/rv_decode_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_ctrl_decoder.sv
hw/rv_gpr_file.sv
hw/rv_decode_stage.sv
hw/rv_decode_unit.sv
tests/rv_decode_unit_tb.sv

// File: tests/rv_decode_unit_tb.sv
// directed testbench for the rv64im decode unit, checks decode fields, immediates and gprs
`default_nettype none

module rv_decode_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_decode_pkg::*;

  // reset, arith, imm, mem, ctrl, gpr, flags
  localparam int TEST_CYCLES = 9 + 43 + 24 + 11 + 8 + 13 + 8;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic       i_clk, i_reset, i_inst_valid, i_wb_en;
  inst_t      i_inst;
  reg_addr_t  i_wb_addr, o_rd;
  xlen_t      i_wb_data, o_rs1_data, o_rs2_data, o_imm;
  alu_op_t    o_alu_op;
  alu_b_src_t o_alu_b_src;
  br_func_t   o_br_func;
  mem_op_t    o_mem_op;
  logic       o_valid, o_alu_a_pc, o_reg_wr, o_mem_rd, o_mem_wr;
  logic       o_word_cut, o_ebreak, o_illegal;

  logic [31:0] lfsr = 32'h2276_4dbb;
  xlen_t       model [32];   // expected gpr contents
  logic        failed = 1'b0;
  int          cycles = 0;

  rv_decode_unit uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("SIMULATION FAILED");
      $fatal(1, "timeout, run went past %0d cycles", MAX_CYCLES);
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};   // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // instruction builders, straight from the isa field layout
  function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  // b holds imm[12:1]
  function automatic inst_t b_type(logic [11:0] b, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {b[11], b[9:4], rs2, rs1, f3, b[3:0], b[10], OP_BRANCH};
  endfunction

  function automatic inst_t u_type(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  // j holds imm[20:1]
  function automatic inst_t j_type(logic [19:0] j, reg_addr_t rd);
    return {j[19], j[9:0], j[10], j[18:11], rd, OP_JAL};
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want)
      else begin
        failed = 1'b1;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, want, got);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch on %s", name);
      end
  endtask

  // inputs change on the falling edge, outputs are sampled just after the rising edge
  task automatic drive(input inst_t inst, input logic valid, input logic wb_en,
                       input reg_addr_t wb_addr, input xlen_t wb_data);
    @(negedge i_clk);
    i_inst       = inst;
    i_inst_valid = valid;
    i_wb_en      = wb_en;
    i_wb_addr    = wb_addr;
    i_wb_data    = wb_data;
    @(posedge i_clk);
    #1;
  endtask

  task automatic issue(input inst_t inst);
    drive(inst, 1'b1, 1'b0, '0, '0);
  endtask

  task automatic arith_check(input inst_t inst, input alu_op_t alu, input logic word,
                             input alu_b_src_t bsrc);
    issue(inst);
    expect_eq("o_alu_op", o_alu_op, alu);
    expect_eq("o_word_cut", o_word_cut, word);
    expect_eq("o_reg_wr", o_reg_wr, 1'b1);
    expect_eq("o_alu_b_src", o_alu_b_src, bsrc);
    expect_eq("o_illegal", o_illegal, 1'b0);
  endtask

  task automatic arith_ops();
    alu_op_t     base_ops [8];
    alu_op_t     m_ops [8];
    logic [63:0] r;
    logic [11:0] imm;
    base_ops = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    m_ops    = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM,
                 ALU_REMU};
    for (int f = 0; f < 8; f++) begin
      draw_bits(12, r);
      imm = (f == 1 || f == 5) ? {6'b0, r[5:0]} : r[11:0];  // shifts keep funct7 clear
      arith_check(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3, OP_REG), base_ops[f], 1'b0, SRC_B_RS2);
      arith_check(r_type(7'h01, 5'd2, 5'd1, 3'(f), 5'd3, OP_REG), m_ops[f], 1'b0, SRC_B_RS2);
      arith_check(i_type(imm, 5'd1, 3'(f), 5'd3, OP_IMM), base_ops[f], 1'b0, SRC_B_IMM);
      if (f inside {0, 1, 5}) begin
        arith_check(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3, OP_REG_32), base_ops[f], 1'b1,
                    SRC_B_RS2);
        imm = (f == 0) ? r[11:0] : {7'b0, r[4:0]};
        arith_check(i_type(imm, 5'd1, 3'(f), 5'd3, OP_IMM_32), base_ops[f], 1'b1, SRC_B_IMM);
      end
      if (f inside {0, 4, 5, 6, 7}) begin
        arith_check(r_type(7'h01, 5'd2, 5'd1, 3'(f), 5'd3, OP_REG_32), m_ops[f], 1'b1,
                    SRC_B_RS2);
      end
    end
    draw_bits(6, r);
    arith_check(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG), ALU_SUB, 1'b0, SRC_B_RS2);
    arith_check(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, OP_REG), ALU_SRA, 1'b0, SRC_B_RS2);
    arith_check(i_type({6'b010000, r[5:0]}, 5'd1, 3'd5, 5'd3, OP_IMM), ALU_SRA, 1'b0, SRC_B_IMM);
    arith_check(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG_32), ALU_SUB, 1'b1, SRC_B_RS2);
    arith_check(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, OP_REG_32), ALU_SRA, 1'b1, SRC_B_RS2);
    arith_check(i_type({7'b0100000, r[4:0]}, 5'd1, 3'd5, 5'd3, OP_IMM_32), ALU_SRA, 1'b1,
                SRC_B_IMM);
    arith_check(u_type(20'h12345, 5'd3, OP_LUI), ALU_COPY_IMM, 1'b0, SRC_B_IMM);
    expect_eq("o_alu_a_pc", o_alu_a_pc, 1'b0);
    arith_check(u_type(20'h54321, 5'd3, OP_AUIPC), ALU_ADD, 1'b0, SRC_B_IMM);
    expect_eq("o_alu_a_pc", o_alu_a_pc, 1'b1);
  endtask

  task automatic immediates();
    logic [63:0] r;
    for (int n = 0; n < 4; n++) begin
      draw_bits(12, r);
      issue(i_type(r[11:0], 5'd1, 3'd0, 5'd3, OP_IMM));
      expect_eq("o_imm", o_imm, {{52{r[11]}}, r[11:0]});
      draw_bits(20, r);
      issue(u_type(r[19:0], 5'd3, OP_LUI));
      expect_eq("o_imm", o_imm, {{32{r[19]}}, r[19:0], 12'b0});
      draw_bits(12, r);
      issue(s_type(r[11:0], 5'd2, 5'd1, 3'd3));
      expect_eq("o_imm", o_imm, {{52{r[11]}}, r[11:0]});
      draw_bits(12, r);
      issue(b_type(r[11:0], 5'd2, 5'd1, 3'd0));
      expect_eq("o_imm", o_imm, {{51{r[11]}}, r[11:0], 1'b0});
      draw_bits(20, r);
      issue(j_type(r[19:0], 5'd1));
      expect_eq("o_imm", o_imm, {{43{r[19]}}, r[19:0], 1'b0});
      issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG));
      expect_eq("o_imm", o_imm, 64'd0);
    end
  endtask

  task automatic memory_ops();
    mem_op_t     ld_ops [7];
    logic [63:0] r;
    ld_ops = '{MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU};
    for (int f = 0; f < 11; f++) begin
      draw_bits(12, r);
      if (f < 7) begin
        issue(i_type(r[11:0], 5'd1, 3'(f), 5'd3, OP_LOAD));
        expect_eq("o_mem_op", o_mem_op, ld_ops[f]);
      end else begin
        issue(s_type(r[11:0], 5'd2, 5'd1, 3'(f - 7)));
        expect_eq("o_mem_op", o_mem_op, ld_ops[f - 7]);  // signed code of the width
      end
      expect_eq("o_mem_rd", o_mem_rd, f < 7);
      expect_eq("o_mem_wr", o_mem_wr, f >= 7);
      expect_eq("o_reg_wr", o_reg_wr, f < 7);
      expect_eq("o_alu_op", o_alu_op, ALU_ADD);
    end
  endtask

  task automatic control_transfer();
    logic [2:0] f3s [6];
    br_func_t   brs [6];
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    brs = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LT, BR_GE};
    for (int k = 0; k < 6; k++) begin
      issue(b_type(12'h0a5, 5'd2, 5'd1, f3s[k]));
      expect_eq("o_br_func", o_br_func, brs[k]);
      expect_eq("o_alu_op", o_alu_op, (k >= 4) ? ALU_SLTU : ALU_SLT);
      expect_eq("o_alu_a_pc", o_alu_a_pc, 1'b0);
      expect_eq("o_reg_wr", o_reg_wr, 1'b0);
    end
    issue(j_type(20'h00100, 5'd1));
    expect_eq("o_br_func", o_br_func, BR_JAL);
    expect_eq("o_alu_a_pc", o_alu_a_pc, 1'b1);
    expect_eq("o_alu_b_src", o_alu_b_src, SRC_B_FOUR);
    issue(i_type(12'h010, 5'd1, 3'd0, 5'd1, OP_JALR));
    expect_eq("o_br_func", o_br_func, BR_JALR);
    expect_eq("o_alu_a_pc", o_alu_a_pc, 1'b1);
    expect_eq("o_alu_b_src", o_alu_b_src, SRC_B_FOUR);
  endtask

  task automatic register_file();
    reg_addr_t   addrs [6];
    logic [63:0] r;
    for (int k = 0; k < 6; k++) begin
      draw_bits(5, r);
      addrs[k] = (r[4:0] == 5'd0) ? 5'd31 : r[4:0];
      draw_bits(64, r);
      model[addrs[k]] = r;
      drive('0, 1'b0, 1'b1, addrs[k], r);
    end
    for (int k = 0; k < 6; k += 2) begin
      issue(r_type(7'h00, addrs[k + 1], addrs[k], 3'd0, 5'd4, OP_REG));
      expect_eq("o_rs1_data", o_rs1_data, model[addrs[k]]);
      expect_eq("o_rs2_data", o_rs2_data, model[addrs[k + 1]]);
    end
    draw_bits(64, r);
    model[addrs[0]] = r;  // read and write in one cycle
    drive(r_type(7'h00, addrs[1], addrs[0], 3'd0, 5'd4, OP_REG), 1'b1, 1'b1, addrs[0], r);
    expect_eq("o_rs1_data", o_rs1_data, model[addrs[0]]);
    expect_eq("o_rs2_data", o_rs2_data, model[addrs[1]]);
    draw_bits(64, r);
    drive('0, 1'b0, 1'b1, 5'd0, r);
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd4, OP_REG));
    expect_eq("o_rs1_data", o_rs1_data, 64'd0);
    drive(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd4, OP_REG), 1'b1, 1'b1, 5'd0, r);
    expect_eq("o_rs2_data", o_rs2_data, 64'd0);
  endtask

  task automatic flags_and_pipeline();
    issue(32'h0000_0000);
    expect_eq("o_illegal", o_illegal, 1'b0);
    expect_eq("o_ebreak", o_ebreak, 1'b0);
    issue(32'h0010_0073);  // ebreak
    expect_eq("o_illegal", o_illegal, 1'b0);
    expect_eq("o_ebreak", o_ebreak, 1'b1);
    issue(32'h0000_007f);
    expect_eq("o_illegal", o_illegal, 1'b1);
    issue(i_type(12'h008, 5'd1, 3'd3, 5'd5, OP_LOAD));
    expect_eq("o_valid", o_valid, 1'b1);
    expect_eq("o_rd", o_rd, 5'd5);
    expect_eq("o_mem_rd", o_mem_rd, 1'b1);
    issue(s_type(12'h010, 5'd2, 5'd1, 3'd3));
    expect_eq("o_valid", o_valid, 1'b1);
    expect_eq("o_mem_wr", o_mem_wr, 1'b1);
    issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd7, OP_REG));
    expect_eq("o_rd", o_rd, 5'd7);
    expect_eq("o_mem_op", o_mem_op, MEM_NONE);
    drive(i_type(12'h008, 5'd1, 3'd3, 5'd9, OP_LOAD), 1'b0, 1'b0, '0, '0);
    expect_eq("o_valid", o_valid, 1'b0);
    expect_eq("o_reg_wr", o_reg_wr, 1'b0);
    expect_eq("o_mem_rd", o_mem_rd, 1'b0);
    expect_eq("o_rd", o_rd, 5'd7);      // held over the bubble
    expect_eq("o_mem_op", o_mem_op, MEM_NONE);
    drive(s_type(12'h010, 5'd2, 5'd1, 3'd3), 1'b0, 1'b0, '0, '0);
    expect_eq("o_mem_wr", o_mem_wr, 1'b0);
  endtask

  initial begin
    i_reset      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_wb_en      = 1'b0;
    i_wb_addr    = '0;
    i_wb_data    = '0;
    repeat (8) @(posedge i_clk);
    #1;
    expect_eq("o_valid", o_valid, 1'b0);
    expect_eq("o_reg_wr", o_reg_wr, 1'b0);
    expect_eq("o_mem_rd", o_mem_rd, 1'b0);
    expect_eq("o_mem_wr", o_mem_wr, 1'b0);
    expect_eq("o_mem_op", o_mem_op, MEM_NONE);
    @(negedge i_clk);
    i_reset = 1'b0;
    arith_ops();
    immediates();
    memory_ops();
    control_transfer();
    register_file();
    flags_and_pipeline();
    if (!failed) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
